// File: hdl/mac_pkg.sv
// --------------------
// shared widths and row types for the booth multiply-add unit
// operands are 17 bits, with the top bit acting as sign or extension bit
// all arithmetic wraps modulo 2**PROD_W
// --------------------

package mac_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int DATA_W = 16;
  // operand plus one extension bit
  localparam int OP_W = DATA_W + 1;
  // full product width, also the width of every row
  localparam int PROD_W = 2 * OP_W;

  // --------------------
  // row counts
  // --------------------
  // radix-4 digits needed to cover OP_W bits
  localparam int NUM_DIGITS = (OP_W + 1) / 2;
  // booth rows plus the subtract correction row
  localparam int NUM_ROWS = NUM_DIGITS + 1;
  // two sum/carry pairs plus two untouched rows
  localparam int S1_ROWS = 6;

  // --------------------
  // types
  // --------------------
  typedef logic [OP_W-1:0] op_t;
  typedef logic [PROD_W-1:0] prod_t;

  // every row is already placed at its column weight
  typedef prod_t [NUM_ROWS-1:0] pp_array_t;

  // carry-save state held between the two stages
  // carry rows are stored already shifted to their weight
  typedef struct packed {
    prod_t [S1_ROWS-1:0] row;
  } s1_rows_t;

endpackage

// File: hdl/compressor_42.sv
// --------------------
// bitwise 4:2 carry-save row of any width
// carry out of the top bit is dropped, so results wrap modulo 2**WIDTH
// the ca row has the same weight as s, the caller shifts it by one
// --------------------

module compressor_42 #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] p0,
  input  logic [WIDTH-1:0] p1,
  input  logic [WIDTH-1:0] p2,
  input  logic [WIDTH-1:0] p3,
  output logic [WIDTH-1:0] s,
  output logic [WIDTH-1:0] ca
);

  logic [WIDTH-1:0] s_mid;
  logic [WIDTH-1:0] cout;
  logic [WIDTH-1:0] cin;

  // first full-adder row over p0..p2
  assign s_mid = p0 ^ p1 ^ p2;
  assign cout  = (p0 & p1) | (p0 & p2) | (p1 & p2);

  // intermediate carry moves one column up
  assign cin = cout << 1;

  // second full-adder row folds in p3 and the chained carry
  assign s  = s_mid ^ p3 ^ cin;
  assign ca = (s_mid & p3) | (s_mid & cin) | (p3 & cin);

endmodule

// File: hdl/booth_pp_gen.sv
// --------------------
// radix-4 booth partial products for 17-bit signed operands
// sub_vld inverts the multiplicand and adds the multiplier as a row
// the negate bit of the top digit is folded into the last row
// --------------------

module booth_pp_gen import mac_pkg::*; (
  input  op_t       multiplicand,
  input  op_t       multiplier,
  input  logic      sub_vld,
  output pp_array_t pp
);

  op_t                   mcand;
  logic [OP_W+1:0]       mult_ext;
  logic [OP_W:0]         part [NUM_DIGITS];
  logic [NUM_DIGITS-1:0] neg;

  // ~a*b + b gives -a*b
  assign mcand = sub_vld ? ~multiplicand : multiplicand;

  // one zero below bit 0 and one sign copy on top
  assign mult_ext = {multiplier[OP_W-1], multiplier, 1'b0};

  // --------------------
  // digit select
  // --------------------
  always_comb begin
    logic [2:0]    trip;
    logic [OP_W:0] mag;
    trip = '0;
    mag  = '0;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      trip = mult_ext[2*i +: 3];
      case (trip)
        3'b001, 3'b010, 3'b101, 3'b110: mag = {mcand[OP_W-1], mcand};
        3'b011, 3'b100:                 mag = {mcand, 1'b0};
        default:                        mag = '0;
      endcase
      // 111 selects zero and stays positive
      neg[i]  = trip[2] & ~(trip[1] & trip[0]);
      part[i] = neg[i] ? ~mag : mag;
    end
  end

  // --------------------
  // row placement
  // --------------------
  always_comb begin
    pp = '0;
    // row 0 carries the low end of the compensation constant
    pp[0][OP_W-1:0]    = part[0][OP_W-1:0];
    pp[0][OP_W+2 -: 3] = {~part[0][OP_W], part[0][OP_W], part[0][OP_W]};
    for (int i = 1; i < NUM_DIGITS; i++) begin
      pp[i][2*i +: OP_W] = part[i][OP_W-1:0];
      pp[i][2*i+OP_W]    = ~part[i][OP_W];
      // negate bit of the digit below sits in the free column
      pp[i][2*i-2]       = neg[i-1];
    end
    // constant bits, the top row's one falls past PROD_W
    for (int i = 1; i < NUM_DIGITS - 1; i++) begin
      pp[i][2*i+OP_W+1] = 1'b1;
    end
    // sign-extended multiplier plus the top digit's negate bit
    if (sub_vld) begin
      pp[NUM_ROWS-1] = {{(PROD_W-DATA_W){multiplier[OP_W-1] & multiplier[OP_W-2]}},
                        multiplier[DATA_W-1:0]};
    end else begin
      pp[NUM_ROWS-1][DATA_W] = neg[NUM_DIGITS-1];
    end
  end

endmodule

// File: hdl/reduce_stage1.sv
// --------------------
// first reduction level and the pipe1 register bank
// rows advance only while pipe1_down is high
// --------------------

module reduce_stage1 import mac_pkg::*; (
  input  logic      pipe1_clk,
  input  logic      cpurst_b,
  input  logic      pipe1_down,
  input  pp_array_t pp,
  output s1_rows_t  rows
);

  prod_t    s_lo;
  prod_t    c_lo;
  prod_t    s_hi;
  prod_t    c_hi;
  s1_rows_t rows_d;

  // --------------------
  // 4:2 level
  // --------------------
  // booth rows 0..3
  compressor_42 #(.WIDTH(PROD_W)) u_comp_lo (
    .p0 (pp[0]),
    .p1 (pp[1]),
    .p2 (pp[2]),
    .p3 (pp[3]),
    .s  (s_lo),
    .ca (c_lo)
  );

  // booth rows 4..7
  compressor_42 #(.WIDTH(PROD_W)) u_comp_hi (
    .p0 (pp[4]),
    .p1 (pp[5]),
    .p2 (pp[6]),
    .p3 (pp[7]),
    .s  (s_hi),
    .ca (c_hi)
  );

  // carries go in pre-shifted, rows 8 and 9 pass straight through
  assign rows_d.row[0] = s_lo;
  assign rows_d.row[1] = {c_lo[PROD_W-2:0], 1'b0};
  assign rows_d.row[2] = s_hi;
  assign rows_d.row[3] = {c_hi[PROD_W-2:0], 1'b0};
  assign rows_d.row[4] = pp[8];
  assign rows_d.row[5] = pp[9];

  // --------------------
  // pipe1 registers
  // --------------------
  always_ff @(posedge pipe1_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      rows <= '0;
    end else if (pipe1_down) begin
      rows <= rows_d;
    end
  end

  // operands feeding the generator must be known once they are captured
  a_rows_known: assert property (
    @(posedge pipe1_clk) disable iff (!cpurst_b)
    !$isunknown(rows)
  );

endmodule

// File: hdl/reduce_stage2.sv
// --------------------
// final reduction with the addend, pipe2 registers and carry-propagate add
// the addend is sampled here, one edge after its operands
// product is combinational from the pipe2 registers
// --------------------

module reduce_stage2 import mac_pkg::*; (
  input  logic     pipe1_clk,
  input  logic     cpurst_b,
  input  logic     pipe2_down,
  input  s1_rows_t rows,
  input  prod_t    addend,
  output prod_t    product
);

  prod_t s_a;
  prod_t c_a;
  prod_t s_b;
  prod_t c_b;
  prod_t s_f;
  prod_t c_f;
  prod_t sum_q;
  prod_t carry_q;

  // --------------------
  // first 4:2 level
  // --------------------
  // the two sum/carry pairs from stage 1
  compressor_42 #(.WIDTH(PROD_W)) u_comp_a (
    .p0 (rows.row[0]),
    .p1 (rows.row[1]),
    .p2 (rows.row[2]),
    .p3 (rows.row[3]),
    .s  (s_a),
    .ca (c_a)
  );

  // top booth row, subtract row and addend
  compressor_42 #(.WIDTH(PROD_W)) u_comp_b (
    .p0 (rows.row[4]),
    .p1 (rows.row[5]),
    .p2 (addend),
    .p3 ('0),
    .s  (s_b),
    .ca (c_b)
  );

  // --------------------
  // second 4:2 level
  // --------------------
  compressor_42 #(.WIDTH(PROD_W)) u_comp_f (
    .p0 (s_a),
    .p1 ({c_a[PROD_W-2:0], 1'b0}),
    .p2 (s_b),
    .p3 ({c_b[PROD_W-2:0], 1'b0}),
    .s  (s_f),
    .ca (c_f)
  );

  // --------------------
  // pipe2 registers
  // --------------------
  always_ff @(posedge pipe1_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      sum_q   <= '0;
      carry_q <= '0;
    end else if (pipe2_down) begin
      sum_q   <= s_f;
      carry_q <= {c_f[PROD_W-2:0], 1'b0};
    end
  end

  // carry-propagate add, wraps at PROD_W
  assign product = sum_q + carry_q;

  // a stalled stage 2 must not let the result move
  a_hold_product: assert property (
    @(posedge pipe1_clk) disable iff (!cpurst_b)
    !pipe2_down |=> $stable(product)
  );

endmodule

// File: hdl/booth_mac_top.sv
// --------------------
// booth radix-4 multiply-add, two stages on pipe1_clk
// product = addend +/- multiplicand * multiplier, modulo 2**34
// addend is due one cycle after its operands
// --------------------

module booth_mac_top import mac_pkg::*; (
  input  logic  pipe1_clk,
  input  logic  cpurst_b,
  input  logic  pipe1_down,
  input  logic  pipe2_down,
  input  logic  sub_vld,
  input  op_t   multiplicand,
  input  op_t   multiplier,
  input  prod_t addend,
  output prod_t product
);

  pp_array_t pp;
  s1_rows_t  s1_rows;

  // partial products
  booth_pp_gen u_pp_gen (
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .sub_vld      (sub_vld),
    .pp           (pp)
  );

  // early reduction and pipe1 registers
  reduce_stage1 u_stage1 (
    .pipe1_clk  (pipe1_clk),
    .cpurst_b   (cpurst_b),
    .pipe1_down (pipe1_down),
    .pp         (pp),
    .rows       (s1_rows)
  );

  // late reduction with addend, pipe2 registers and final add
  reduce_stage2 u_stage2 (
    .pipe1_clk  (pipe1_clk),
    .cpurst_b   (cpurst_b),
    .pipe2_down (pipe2_down),
    .rows       (s1_rows),
    .addend     (addend),
    .product    (product)
  );

endmodule

// File: sim/tb_booth_mac.sv
// --------------------
// testbench for booth_mac_top with random, corner and stall traffic
// random operands carry a sign copy or a zero as extension bit
// expected results follow the stage timing with the addend one edge late
// --------------------

module tb_booth_mac import mac_pkg::*; ();

  localparam int CLK_PERIOD    = 4;
  localparam int DRIVE_DLY     = 1;
  localparam int RESET_CYCLES  = 3;
  localparam int IDLE_CYCLES   = 4;
  localparam int ADD_OPS       = 200;
  localparam int SUB_OPS       = 200;
  localparam int NUM_CORNERS   = 7;
  localparam int STALL1_CYCLES = 150;
  localparam int STALL2_CYCLES = 150;
  localparam int DRAIN_CYCLES  = 4;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + ADD_OPS + SUB_OPS
                               + 2 * NUM_CORNERS * NUM_CORNERS + STALL1_CYCLES
                               + STALL2_CYCLES + DRAIN_CYCLES + 1;

  // test ids travel through the model pipeline with each operation
  localparam int T_RESET  = 0;
  localparam int T_ADD    = 1;
  localparam int T_SUB    = 2;
  localparam int T_CORNER = 3;
  localparam int T_STALL1 = 4;
  localparam int T_STALL2 = 5;

  logic        pipe1_clk;
  logic        cpurst_b;
  logic        pipe1_down;
  logic        pipe2_down;
  logic        sub_vld;
  op_t         multiplicand;
  op_t         multiplier;
  prod_t       addend;
  prod_t       product;
  logic [31:0] lfsr;
  int          cur_tid;

  // model pipeline state
  prod_t s1_term;
  int    s1_tid;
  prod_t exp_product;
  int    out_tid;
  prod_t prev_product;
  logic  held;

  // most negative 16 and 17 bit, zero, all ones, max unsigned, max positive, one
  op_t corner_ops [NUM_CORNERS] = '{17'h18000, 17'h10000, 17'h00000, 17'h1ffff,
                                    17'h0ffff, 17'h07fff, 17'h00001};

  initial pipe1_clk = 1'b0;
  always #(CLK_PERIOD / 2) pipe1_clk = ~pipe1_clk;

  booth_mac_top u_dut (
    .pipe1_clk    (pipe1_clk),
    .cpurst_b     (cpurst_b),
    .pipe1_down   (pipe1_down),
    .pipe2_down   (pipe2_down),
    .sub_vld      (sub_vld),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .addend       (addend),
    .product      (product)
  );

  // --------------------
  // helpers
  // --------------------
  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // signed product term with both operands read as 17-bit signed, negated for subtract
  function automatic prod_t signed_mac_term(input op_t a, input op_t b, input logic sub);
    prod_t sa;
    prod_t sb;
    prod_t p;
    sa = {{(PROD_W-OP_W){a[OP_W-1]}}, a};
    sb = {{(PROD_W-OP_W){b[OP_W-1]}}, b};
    p  = sa * sb;
    if (sub) begin
      return -p;
    end else begin
      return p;
    end
  endfunction

  function automatic string test_name(input int tid);
    case (tid)
      T_RESET:  return "reset";
      T_ADD:    return "random_add";
      T_SUB:    return "random_sub";
      T_CORNER: return "corner";
      T_STALL1: return "stage1_stall";
      default:  return "stage2_stall";
    endcase
  endfunction

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input int tid, input prod_t exp_val, input prod_t act_val);
    $display("Error: test %s expected %h actual %h", test_name(tid), exp_val, act_val);
    stop_on_failure();
  endtask

  // one lfsr step per bit taken
  task automatic rand_bits(input int n, output prod_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[PROD_W-2:0], lfsr[0]};
    end
  endtask

  task automatic rand_operand(output op_t v);
    prod_t r;
    rand_bits(OP_W, r);
    // top bit picks a signed or an unsigned reading of the low half
    if (r[DATA_W]) begin
      v = {r[DATA_W-1], r[DATA_W-1:0]};
    end else begin
      v = {1'b0, r[DATA_W-1:0]};
    end
  endtask

  task automatic apply_cycle(input int tid, input op_t a, input op_t b, input logic sub,
                             input prod_t add, input logic p1, input logic p2);
    @(posedge pipe1_clk);
    #DRIVE_DLY;
    cur_tid      = tid;
    multiplicand = a;
    multiplier   = b;
    sub_vld      = sub;
    addend       = add;
    pipe1_down   = p1;
    pipe2_down   = p2;
  endtask

  // --------------------
  // stimulus sequences
  // --------------------
  task automatic run_random(input int tid, input logic sub, input int count, input logic en);
    op_t   a;
    op_t   b;
    prod_t add;
    for (int n = 0; n < count; n++) begin
      rand_operand(a);
      rand_operand(b);
      rand_bits(PROD_W, add);
      apply_cycle(tid, a, b, sub, add, en, en);
    end
  endtask

  task automatic run_corners();
    prod_t r;
    prod_t add;
    int    k;
    k = 0;
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < NUM_CORNERS; i++) begin
        for (int j = 0; j < NUM_CORNERS; j++) begin
          rand_bits(PROD_W, r);
          // addend cycles through zero, all ones and random
          case (k % 3)
            0:       add = '0;
            1:       add = '1;
            default: add = r;
          endcase
          apply_cycle(T_CORNER, corner_ops[i], corner_ops[j], s[0], add, 1'b1, 1'b1);
          k++;
        end
      end
    end
  endtask

  task automatic run_stall1();
    op_t   a;
    op_t   b;
    prod_t add;
    prod_t r;
    for (int n = 0; n < STALL1_CYCLES; n++) begin
      rand_operand(a);
      rand_operand(b);
      rand_bits(PROD_W, add);
      rand_bits(3, r);
      // stage 1 advances about one cycle in four
      apply_cycle(T_STALL1, a, b, r[2], add, r[1:0] == 2'b00, 1'b1);
    end
  endtask

  task automatic run_stall2();
    op_t   a;
    op_t   b;
    prod_t add;
    prod_t r;
    for (int n = 0; n < STALL2_CYCLES; n++) begin
      rand_operand(a);
      rand_operand(b);
      rand_bits(PROD_W, add);
      rand_bits(4, r);
      // stage 2 advances one cycle in four and stage 1 sometimes runs over it
      apply_cycle(T_STALL2, a, b, r[3], add, r[2] | (r[1:0] == 2'b00), r[1:0] == 2'b00);
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  always @(posedge pipe1_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      s1_term      <= '0;
      s1_tid       <= T_RESET;
      exp_product  <= '0;
      out_tid      <= T_RESET;
      prev_product <= '0;
      held         <= 1'b0;
    end else begin
      // stage 2 adds the addend to the term held before this edge
      if (pipe2_down) begin
        exp_product <= s1_term + addend;
        out_tid     <= s1_tid;
      end
      if (pipe1_down) begin
        s1_term <= signed_mac_term(multiplicand, multiplier, sub_vld);
        s1_tid  <= cur_tid;
      end
      prev_product <= product;
      held         <= !pipe2_down;
    end
  end

  // product and model are settled at the falling edge
  a_reset_zero: assert property (
    @(negedge pipe1_clk) disable iff (!cpurst_b)
    (cur_tid == T_RESET) |-> (product == '0)
  ) else report_mismatch(T_RESET, '0, product);

  a_product_match: assert property (
    @(negedge pipe1_clk) disable iff (!cpurst_b)
    product == exp_product
  ) else report_mismatch(out_tid, exp_product, product);

  a_stall_hold: assert property (
    @(negedge pipe1_clk) disable iff (!cpurst_b)
    held |-> (product == prev_product)
  ) else report_mismatch(cur_tid, prev_product, product);

  // --------------------
  // main sequence
  // --------------------
  initial begin
    cpurst_b     = 1'b0;
    pipe1_down   = 1'b0;
    pipe2_down   = 1'b0;
    sub_vld      = 1'b0;
    multiplicand = '0;
    multiplier   = '0;
    addend       = '0;
    lfsr         = 32'h673b;
    cur_tid      = T_RESET;
    repeat (RESET_CYCLES) @(posedge pipe1_clk);
    #DRIVE_DLY;
    cpurst_b = 1'b1;
    // inputs move with both enables low and product stays zero
    run_random(T_RESET, 1'b0, IDLE_CYCLES, 1'b0);
    run_random(T_ADD, 1'b0, ADD_OPS, 1'b1);
    run_random(T_SUB, 1'b1, SUB_OPS, 1'b1);
    run_corners();
    run_stall1();
    run_stall2();
    run_random(T_ADD, 1'b0, DRAIN_CYCLES, 1'b1);
    @(posedge pipe1_clk);
    $display("Simulation completed successfully");
    $finish;
  end

  // watchdog
  initial begin
    #((TOTAL_CYCLES + 20) * CLK_PERIOD);
    $display("timeout: the test sequence did not reach its end in time");
    stop_on_failure();
  end

endmodule

// File: build.f
hdl/mac_pkg.sv
hdl/compressor_42.sv
hdl/booth_pp_gen.sv
hdl/reduce_stage1.sv
hdl/reduce_stage2.sv
hdl/booth_mac_top.sv
sim/tb_booth_mac.sv

// File: Makefile
# Verilator build and run for the booth multiply-add testbench
# pass or fail is taken from the simulation log

VERILATOR ?= verilator
TOP       ?= tb_booth_mac
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
